// File: sim.f
+incdir+hdl
hdl/SchedulerTypes.sv
hdl/Scheduler.sv
hdl/WakeupMatrix.sv
hdl/IssueSelector.sv
hdl/DividerTracker.sv
hdl/IssueCore.sv
tests/IssueCoreTb.sv

// File: Makefile
# Verilator build and run of the issue scheduler testbench

VERILATOR ?= verilator
TOP       ?= IssueCoreTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: test clean help

test: $(BINARY)
	./$(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

// File: tests/IssueCoreTb.sv
// Random testbench for the issue scheduler top level.
// A mirror of the queue predicts full and the op issued on each pipe
// every cycle; a separate process compares them with the DUT.

`timescale 1ns/1ps
`default_nettype none

`include "scheduler_settings.svh"

module IssueCoreTb import SchedulerTypes::*; ();

    localparam int ClkPeriod  = 100;
    localparam int EntryNum   = `SCHED_ENTRY_NUM;
    localparam int StimCycles = 2000;
    // Stimulus cycles plus reset and drain margin
    localparam int CycleLimit = 3000;
    localparam int MaxOps     = 4096;

    logic       clk;
    logic       rst;
    logic       dispatch;
    DispatchOp  dispatchOp;
    logic       stall;
    EntryVector flushVector;
    logic       full;
    IssuedOp    intIssue;
    IssuedOp    complexIssue;
    IssuedOp    loadIssue;
    IssuedOp    storeIssue;

    IssueCore i_dut (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .dispatchOp   (dispatchOp),
        .stall        (stall),
        .flushVector  (flushVector),
        .full         (full),
        .intIssue     (intIssue),
        .complexIssue (complexIssue),
        .loadIssue    (loadIssue),
        .storeIssue   (storeIssue)
    );

    IssuedOp dutIssue [4];
    assign dutIssue[0] = intIssue;
    assign dutIssue[1] = complexIssue;
    assign dutIssue[2] = loadIssue;
    assign dutIssue[3] = storeIssue;

    string pipeName [4] = '{"int", "complex", "load", "store"};

    // Mirror of the queue, state at the start of the current cycle
    logic     mValid    [EntryNum];
    OpClass   mClass    [EntryNum];
    int       mSeq      [EntryNum];
    logic     mWriteReg [EntryNum];
    PhyTag    mDstTag   [EntryNum];
    PhyTag    mSrcTag   [EntryNum][2];
    logic     mReady    [EntryNum][2];
    WakeupTag mPipeBc   [4];
    logic     mDivPending;
    int       mDivLeft;
    PhyTag    mDivTag;

    int          nextSeq;
    PhyTag       tagCounter;
    logic [31:0] rngState;
    int          cycleCount;
    logic        checksOn;

    // Expected outputs of the current cycle
    logic    expFull;
    IssuedOp expIssue [4];
    // Op sequence number held by each entry this cycle, -1 when free
    int      entrySeq   [EntryNum];
    int      issueCount [MaxOps];
    bit      opFlushed  [MaxOps];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned randBelow(input int unsigned n);
        rngState = xorshift(rngState);
        return rngState % n;
    endfunction

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // Pipe 1 takes multiplies, and divides only while the divider is free
    function automatic logic pipeTakes(input int pipe, input OpClass cls, input logic divFree);
        case (pipe)
            0: return cls == OP_INT;
            1: return (cls == OP_MUL) || ((cls == OP_DIV) && divFree);
            2: return cls == OP_LOAD;
            default: return cls == OP_STORE;
        endcase
    endfunction

    // Reference select: oldest entry with both sources ready for this pipe
    function automatic int oldestReady(input int pipe, input logic divFree);
        int best;
        best = -1;
        for (int i = 0; i < EntryNum; i++) begin
            if (mValid[i] && mReady[i][0] && mReady[i][1]
                && pipeTakes(pipe, mClass[i], divFree)
                && (best < 0 || mSeq[i] < mSeq[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    function automatic logic tagBroadcast(input PhyTag tag, input WakeupTag divBc);
        logic hit;
        hit = divBc.valid && (divBc.tag == tag);
        for (int p = 0; p < 4; p++) begin
            if (mPipeBc[p].valid && (mPipeBc[p].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic int lowestFree();
        int free;
        free = -1;
        for (int i = EntryNum - 1; i >= 0; i--) begin
            if (!mValid[i]) begin
                free = i;
            end
        end
        return free;
    endfunction

    // A waiting source only names a tag that is still going to be broadcast
    function automatic logic [`SCHED_TAG_WIDTH+1:0] pickSource();
        PhyTag cands [$];
        PhyTag tag;
        logic  valid;
        logic  ready;
        for (int i = 0; i < EntryNum; i++) begin
            if (mValid[i] && mWriteReg[i]) cands.push_back(mDstTag[i]);
        end
        for (int p = 0; p < 4; p++) begin
            if (mPipeBc[p].valid) cands.push_back(mPipeBc[p].tag);
        end
        if (mDivPending) cands.push_back(mDivTag);
        valid = (randBelow(4) != 0);
        tag = PhyTag'(randBelow(64));
        ready = (randBelow(2) == 0);
        if (valid) begin
            ready = 1'b1;
            if (cands.size() > 0 && randBelow(2) == 0) begin
                tag = cands[randBelow(32'(cands.size()))];
                ready = 1'b0;
            end
        end
        return {valid, ready, tag};
    endfunction

    function automatic logic mirrorBusy();
        logic busy;
        busy = mDivPending;
        for (int i = 0; i < EntryNum; i++) busy = busy | mValid[i];
        for (int p = 0; p < 4; p++) busy = busy | mPipeBc[p].valid;
        return busy;
    endfunction

    // Drive one cycle from the falling edge and advance the mirror past its end
    task automatic stepCycle(input logic stimOn);
        WakeupTag   divBc;
        logic       divFreeNow;
        int         grantEntry [4];
        logic       issueNow [4];
        EntryVector issuedMask;
        int         freeEntry;
        int         pivot;
        int         g;
        DispatchOp  op;
        divBc.valid = mDivPending && (mDivLeft == 0);
        divBc.tag = mDivTag;
        divFreeNow = !mDivPending || (mDivLeft == 0);
        freeEntry = lowestFree();

        stall = stimOn && (randBelow(16) == 0);
        flushVector = '0;
        if (stimOn && randBelow(64) == 0) begin
            pivot = int'(randBelow(EntryNum));
            // Recovery clears the picked op and every younger one
            for (int i = 0; i < EntryNum; i++) begin
                if (mValid[pivot] && mValid[i] && mSeq[i] >= mSeq[pivot]) flushVector[i] = 1'b1;
            end
        end
        dispatch = stimOn && (flushVector == '0) && (freeEntry >= 0) && (randBelow(4) != 0);
        op = '0;
        if (dispatch) begin
            op.opClass = OpClass'(randBelow(5));
            op.opId = OpId'(nextSeq);
            op.writeReg = (op.opClass != OP_STORE) && (randBelow(8) != 0);
            op.dstTag = tagCounter;
            tagCounter = tagCounter + PhyTag'(1);
            {op.srcValidA, op.srcReadyA, op.srcTagA} = pickSource();
            {op.srcValidB, op.srcReadyB, op.srcTagB} = pickSource();
        end
        dispatchOp = op;

        expFull = (freeEntry < 0);
        for (int i = 0; i < EntryNum; i++) begin
            entrySeq[i] = mValid[i] ? mSeq[i] : -1;
        end
        issuedMask = '0;
        for (int p = 0; p < 4; p++) begin
            grantEntry[p] = oldestReady(p, divFreeNow);
            issueNow[p] = (grantEntry[p] >= 0) && !stall;
            expIssue[p] = '0;
            if (issueNow[p]) begin
                g = grantEntry[p];
                issuedMask[g] = 1'b1;
                expIssue[p].valid = 1'b1;
                expIssue[p].entry = EntryIndex'(g);
                expIssue[p].opId = OpId'(mSeq[g]);
                expIssue[p].writeReg = mWriteReg[g];
                expIssue[p].dstTag = mDstTag[g];
            end
        end

        // Wakeup by this cycle's broadcasts
        for (int i = 0; i < EntryNum; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (mValid[i] && tagBroadcast(mSrcTag[i][s], divBc)) mReady[i][s] = 1'b1;
            end
            // A flushed op granted in the same cycle still counts as issued
            if (flushVector[i] && !issuedMask[i]) opFlushed[mSeq[i]] = 1'b1;
            if (flushVector[i] || issuedMask[i]) mValid[i] = 1'b0;
        end
        if (dispatch) begin
            mValid[freeEntry] = 1'b1;
            mClass[freeEntry] = op.opClass;
            mSeq[freeEntry] = nextSeq;
            mWriteReg[freeEntry] = op.writeReg;
            mDstTag[freeEntry] = op.dstTag;
            mSrcTag[freeEntry][0] = op.srcTagA;
            mSrcTag[freeEntry][1] = op.srcTagB;
            mReady[freeEntry][0] = !op.srcValidA || op.srcReadyA
                || tagBroadcast(op.srcTagA, divBc);
            mReady[freeEntry][1] = !op.srcValidB || op.srcReadyB
                || tagBroadcast(op.srcTagB, divBc);
            nextSeq++;
        end
        for (int p = 0; p < 4; p++) begin
            g = (grantEntry[p] < 0) ? 0 : grantEntry[p];
            mPipeBc[p].valid = issueNow[p] && mWriteReg[g] && !(p == 1 && mClass[g] == OP_DIV);
            mPipeBc[p].tag = mDstTag[g];
        end
        // Divide result comes back after the divider latency
        if (issueNow[1] && mClass[grantEntry[1]] == OP_DIV) begin
            mDivPending = 1'b1;
            mDivLeft = `SCHED_DIV_LATENCY - 1;
            mDivTag = mDstTag[grantEntry[1]];
        end else if (mDivPending) begin
            if (mDivLeft == 0) mDivPending = 1'b0;
            else mDivLeft--;
        end
        @(negedge clk);
    endtask

    task automatic compareOutputs();
        checkValue(64'(full), 64'(expFull), "full flag");
        for (int p = 0; p < 4; p++) begin
            checkValue(64'(dutIssue[p].valid), 64'(expIssue[p].valid),
                       $sformatf("%s pipe issue valid", pipeName[p]));
            if (expIssue[p].valid) begin
                checkValue(64'(dutIssue[p]), 64'(expIssue[p]),
                           $sformatf("%s pipe issued op", pipeName[p]));
            end
            // Count what the DUT actually issued, by the op held in that entry
            if (dutIssue[p].valid) begin
                issueCount[entrySeq[dutIssue[p].entry]]++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run did not finish within %0d clock cycles", CycleLimit);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // Outputs are compared a quarter period after the inputs change
    initial begin
        forever begin
            @(negedge clk);
            #(ClkPeriod / 4);
            if (checksOn) compareOutputs();
        end
    end

    initial begin
        rst = 1'b1;
        dispatch = 1'b0;
        dispatchOp = '0;
        stall = 1'b0;
        flushVector = '0;
        checksOn = 1'b0;
        rngState = 32'd26539;
        nextSeq = 0;
        tagCounter = '0;
        mDivPending = 1'b0;
        mDivLeft = 0;
        mDivTag = '0;
        for (int i = 0; i < EntryNum; i++) mValid[i] = 1'b0;
        for (int p = 0; p < 4; p++) mPipeBc[p] = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checksOn = 1'b1;
        for (int c = 0; c < StimCycles; c++) stepCycle(1'b1);

        // Drain without stall until the queue and divider are empty
        while (mirrorBusy()) stepCycle(1'b0);
        repeat (2) stepCycle(1'b0);
        checksOn = 1'b0;

        checkValue(64'(full), 64'(0), "full flag after drain");
        for (int s = 0; s < nextSeq; s++) begin
            checkValue(64'(issueCount[s]), opFlushed[s] ? 64'(0) : 64'(1),
                       $sformatf("issue count of op %0d", s));
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule : IssueCoreTb

`default_nettype wire

// File: hdl/IssueCore.sv
// Top of the issue scheduler.
// Takes one dispatched op per cycle and issues up to one op per pipe
// (integer, complex, load, store) per cycle.

`timescale 1ns/1ps
`default_nettype none

module IssueCore import SchedulerTypes::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dispatch,
    input  DispatchOp  dispatchOp,
    input  logic       stall,
    input  EntryVector flushVector,
    output logic       full,
    output IssuedOp    intIssue,
    output IssuedOp    complexIssue,
    output IssuedOp    loadIssue,
    output IssuedOp    storeIssue
);

    PipeRequests requests;
    PipeGrants   grants;
    EntryIndex   writeEntry;
    EntryVector  readyVector;
    EntryVector  issuedVector;
    logic        divFree;
    logic        divIssue;
    PhyTag       divDstTag;
    WakeupTag    divBroadcast;

    Scheduler i_scheduler (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .stall        (stall),
        .dispatchOp   (dispatchOp),
        .flushVector  (flushVector),
        .readyVector  (readyVector),
        .divFree      (divFree),
        .grants       (grants),
        .requests     (requests),
        .writeEntry   (writeEntry),
        .full         (full),
        .divIssue     (divIssue),
        .divDstTag    (divDstTag),
        .issuedVector (issuedVector),
        .intIssue     (intIssue),
        .complexIssue (complexIssue),
        .loadIssue    (loadIssue),
        .storeIssue   (storeIssue)
    );

    WakeupMatrix i_wakeup (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .writeEntry   (writeEntry),
        .dispatchOp   (dispatchOp),
        .issuedVector (issuedVector),
        .intIssue     (intIssue),
        .complexIssue (complexIssue),
        .loadIssue    (loadIssue),
        .storeIssue   (storeIssue),
        .divBroadcast (divBroadcast),
        .readyVector  (readyVector)
    );

    IssueSelector i_selector (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .writeEntry (writeEntry),
        .requests   (requests),
        .grants     (grants)
    );

    DividerTracker i_divider (
        .clk          (clk),
        .rst          (rst),
        .divIssue     (divIssue),
        .divDstTag    (divDstTag),
        .divFree      (divFree),
        .divBroadcast (divBroadcast)
    );

endmodule : IssueCore

`default_nettype wire

// File: hdl/DividerTracker.sv
// Occupancy of the single divider.
// Counts down the divide latency after issue and broadcasts the
// destination tag in the cycle the divider frees up.

`timescale 1ns/1ps
`default_nettype none

`include "scheduler_settings.svh"

module DividerTracker import SchedulerTypes::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     divIssue,
    input  PhyTag    divDstTag,
    output logic     divFree,
    output WakeupTag divBroadcast
);

    localparam int CountWidth = $clog2(`SCHED_DIV_LATENCY + 1);

    logic [CountWidth-1:0] remaining;
    PhyTag heldTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            divBroadcast <= '0;
        end else begin
            // Last busy cycle, result tag goes out next cycle
            divBroadcast.valid <= (remaining == CountWidth'(1));
            divBroadcast.tag <= heldTag;
            if (divIssue) begin
                remaining <= CountWidth'(`SCHED_DIV_LATENCY - 1);
            end else if (remaining != '0) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divIssue) heldTag <= divDstTag;
    end

    assign divFree = (remaining == '0);

    // Scheduler must gate divides on divFree
    assert property (@(posedge clk) disable iff (rst) divIssue |-> divFree);

endmodule : DividerTracker

`default_nettype wire

// File: hdl/IssueSelector.sv
// Oldest-first select for the four issue pipes.
// An age matrix records, per entry, which other entries were dispatched
// before it; each pipe grants the requester with no older requester.

`timescale 1ns/1ps
`default_nettype none

`include "scheduler_settings.svh"

module IssueSelector import SchedulerTypes::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatch,
    input  EntryIndex   writeEntry,
    input  PipeRequests requests,
    output PipeGrants   grants
);

    // Bit j of row i set when entry j is older than entry i
    EntryVector olderThan [`SCHED_ENTRY_NUM];

    function automatic EntryVector selectOldest(input EntryVector req);
        EntryVector grant;
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            grant[i] = req[i] && ((req & olderThan[i]) == '0);
        end
        return grant;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                olderThan[i] <= '0;
            end
        end else if (dispatch) begin
            // New op is younger than every other entry
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                olderThan[i][writeEntry] <= 1'b0;
            end
            olderThan[writeEntry] <= ~(EntryVector'(1) << writeEntry);
        end
    end

    always_comb begin
        grants.intReq     = selectOldest(requests.intReq);
        grants.complexReq = selectOldest(requests.complexReq);
        grants.loadReq    = selectOldest(requests.loadReq);
        grants.storeReq   = selectOldest(requests.storeReq);
    end

    // An entry is never its own elder
    for (genvar i = 0; i < `SCHED_ENTRY_NUM; i++) begin : g_ageCheck
        assert property (@(posedge clk) disable iff (rst) !olderThan[i][i]);
    end

endmodule : IssueSelector

`default_nettype wire

// File: hdl/WakeupMatrix.sv
// Source readiness of queued ops.
// Holds both source tags per entry, compares them against the pipe and
// divide broadcasts and reports which entries have all operands ready.

`timescale 1ns/1ps
`default_nettype none

`include "scheduler_settings.svh"

module WakeupMatrix import SchedulerTypes::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dispatch,
    input  EntryIndex  writeEntry,
    input  DispatchOp  dispatchOp,
    input  EntryVector issuedVector,
    input  IssuedOp    intIssue,
    input  IssuedOp    complexIssue,
    input  IssuedOp    loadIssue,
    input  IssuedOp    storeIssue,
    input  WakeupTag   divBroadcast,
    output EntryVector readyVector
);

    PhyTag srcTagA [`SCHED_ENTRY_NUM];
    PhyTag srcTagB [`SCHED_ENTRY_NUM];
    EntryVector readyA;
    EntryVector readyB;

    // Divides wake through the divider tracker instead
    EntryVector isDivEntry;

    IssuedOp  issuedOps     [4];
    WakeupTag pipeBroadcast [4];

    assign issuedOps[0] = intIssue;
    assign issuedOps[1] = complexIssue;
    assign issuedOps[2] = loadIssue;
    assign issuedOps[3] = storeIssue;

    function automatic logic tagHit(input PhyTag tag);
        logic hit;
        hit = divBroadcast.valid && (divBroadcast.tag == tag);
        for (int p = 0; p < 4; p++) begin
            if (pipeBroadcast[p].valid && (pipeBroadcast[p].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            readyA <= '0;
            readyB <= '0;
            for (int p = 0; p < 4; p++) begin
                pipeBroadcast[p] <= '0;
            end
        end else begin
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                if (tagHit(srcTagA[i])) readyA[i] <= 1'b1;
                if (tagHit(srcTagB[i])) readyB[i] <= 1'b1;
                // Issued entries drop their ready state
                if (issuedVector[i]) begin
                    readyA[i] <= 1'b0;
                    readyB[i] <= 1'b0;
                end
            end
            if (dispatch) begin
                readyA[writeEntry] <= !dispatchOp.srcValidA || dispatchOp.srcReadyA
                    || tagHit(dispatchOp.srcTagA);
                readyB[writeEntry] <= !dispatchOp.srcValidB || dispatchOp.srcReadyB
                    || tagHit(dispatchOp.srcTagB);
            end
            for (int p = 0; p < 4; p++) begin
                pipeBroadcast[p].valid <= issuedOps[p].valid && issuedOps[p].writeReg
                    && !(p == 1 && isDivEntry[issuedOps[p].entry]);
                pipeBroadcast[p].tag <= issuedOps[p].dstTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            srcTagA[writeEntry]    <= dispatchOp.srcTagA;
            srcTagB[writeEntry]    <= dispatchOp.srcTagB;
            isDivEntry[writeEntry] <= (dispatchOp.opClass == OP_DIV);
        end
    end

    assign readyVector = readyA & readyB;

endmodule : WakeupMatrix

`default_nettype wire

// File: hdl/Scheduler.sv
// Issue queue control: entry state, op class flags and issue payload.
// Allocates the lowest free entry at dispatch, raises per-pipe requests
// for ready entries and turns the selector grants into issued ops.

`timescale 1ns/1ps
`default_nettype none

`include "scheduler_settings.svh"

module Scheduler import SchedulerTypes::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatch,
    input  logic        stall,
    input  DispatchOp   dispatchOp,
    input  EntryVector  flushVector,
    input  EntryVector  readyVector,
    input  logic        divFree,
    input  PipeGrants   grants,
    output PipeRequests requests,
    output EntryIndex   writeEntry,
    output logic        full,
    output logic        divIssue,
    output PhyTag       divDstTag,
    output EntryVector  issuedVector,
    output IssuedOp     intIssue,
    output IssuedOp     complexIssue,
    output IssuedOp     loadIssue,
    output IssuedOp     storeIssue
);

    // Set while an entry holds an op waiting for issue
    EntryVector notIssued;

    EntryVector isInt;
    EntryVector isComplex;
    EntryVector isDiv;
    EntryVector isLoad;
    EntryVector isStore;

    OpId   opIdMem     [`SCHED_ENTRY_NUM];
    logic  writeRegMem [`SCHED_ENTRY_NUM];
    PhyTag dstTagMem   [`SCHED_ENTRY_NUM];

    // Gather the payload of the granted entry
    function automatic IssuedOp makeIssue(input EntryVector grant);
        IssuedOp op;
        op = '0;
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            if (grant[i]) begin
                op.entry    = EntryIndex'(i);
                op.opId     = opIdMem[i];
                op.writeReg = writeRegMem[i];
                op.dstTag   = dstTagMem[i];
            end
        end
        op.valid = (|grant) && !stall;
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            notIssued <= '0;
        end else begin
            // Issue and recovery both free the entry
            notIssued <= notIssued & ~issuedVector & ~flushVector;
            if (dispatch) begin
                notIssued[writeEntry] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            isInt[writeEntry]       <= (dispatchOp.opClass == OP_INT);
            isComplex[writeEntry]   <= (dispatchOp.opClass inside {OP_MUL, OP_DIV});
            isDiv[writeEntry]       <= (dispatchOp.opClass == OP_DIV);
            isLoad[writeEntry]      <= (dispatchOp.opClass == OP_LOAD);
            isStore[writeEntry]     <= (dispatchOp.opClass == OP_STORE);
            opIdMem[writeEntry]     <= dispatchOp.opId;
            writeRegMem[writeEntry] <= dispatchOp.writeReg;
            dstTagMem[writeEntry]   <= dispatchOp.dstTag;
        end
    end

    // Lowest free entry takes the next dispatch
    always_comb begin
        full = 1'b1;
        writeEntry = '0;
        for (int i = `SCHED_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!notIssued[i]) begin
                writeEntry = EntryIndex'(i);
                full = 1'b0;
            end
        end
    end

    always_comb begin
        requests.intReq     = notIssued & readyVector & isInt;
        // Only one divide may be in the divider at a time
        requests.complexReq = notIssued & readyVector & isComplex
            & ~(isDiv & {`SCHED_ENTRY_NUM{!divFree}});
        requests.loadReq    = notIssued & readyVector & isLoad;
        requests.storeReq   = notIssued & readyVector & isStore;
    end

    assign issuedVector = stall ? '0
        : (grants.intReq | grants.complexReq | grants.loadReq | grants.storeReq);

    assign intIssue     = makeIssue(grants.intReq);
    assign complexIssue = makeIssue(grants.complexReq);
    assign loadIssue    = makeIssue(grants.loadReq);
    assign storeIssue   = makeIssue(grants.storeReq);

    assign divIssue  = complexIssue.valid && |(grants.complexReq & isDiv);
    assign divDstTag = complexIssue.dstTag;

    // Upstream must hold dispatch back while the queue is full
    assert property (@(posedge clk) disable iff (rst) dispatch |-> !full);

    // Selector grants at most one requesting entry per pipe
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(grants.intReq) && $onehot0(grants.complexReq)
        && $onehot0(grants.loadReq) && $onehot0(grants.storeReq)
        && ((grants & ~requests) == '0));

endmodule : Scheduler

`default_nettype wire

// File: hdl/SchedulerTypes.sv
// Types shared by the issue scheduler blocks.
// Modules import this package in their header.

`default_nettype none

`include "scheduler_settings.svh"

package SchedulerTypes;

    // Kind of micro-op, decides the pipe it issues to
    typedef enum logic [2:0] {
        OP_INT,
        OP_MUL,
        OP_DIV,
        OP_LOAD,
        OP_STORE
    } OpClass;

    typedef logic [`SCHED_TAG_WIDTH-1:0] PhyTag;
    typedef logic [`SCHED_ENTRY_NUM-1:0] EntryVector;
    typedef logic [$clog2(`SCHED_ENTRY_NUM)-1:0] EntryIndex;
    typedef logic [`SCHED_OPID_WIDTH-1:0] OpId;

    // Renamed op as it arrives from dispatch
    typedef struct packed {
        OpClass opClass;
        OpId    opId;
        logic   srcValidA;
        logic   srcReadyA;
        PhyTag  srcTagA;
        logic   srcValidB;
        logic   srcReadyB;
        PhyTag  srcTagB;
        logic   writeReg;
        PhyTag  dstTag;
    } DispatchOp;

    // Op leaving the queue on one pipe
    typedef struct packed {
        logic      valid;
        EntryIndex entry;
        OpId       opId;
        logic      writeReg;
        PhyTag     dstTag;
    } IssuedOp;

    typedef struct packed {
        logic  valid;
        PhyTag tag;
    } WakeupTag;

    // One request vector per pipe
    typedef struct packed {
        EntryVector intReq;
        EntryVector complexReq;
        EntryVector loadReq;
        EntryVector storeReq;
    } PipeRequests;

    // Same layout, each field at most one-hot
    typedef PipeRequests PipeGrants;

endpackage : SchedulerTypes

`default_nettype wire

// File: hdl/scheduler_settings.svh
// Sizing of the four-pipe issue scheduler.
// Include wherever queue, tag or latency sizes are needed; the package
// pulls it in for its type widths.

`ifndef SCHEDULER_SETTINGS_SVH
`define SCHEDULER_SETTINGS_SVH

// Issue queue depth
`define SCHED_ENTRY_NUM 8

// Physical register tag width
`define SCHED_TAG_WIDTH 6

// Width of the op identifier supplied at dispatch
`define SCHED_OPID_WIDTH 8

// Cycles from divide issue to its wakeup broadcast
`define SCHED_DIV_LATENCY 6

`endif
